//--- uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

//////////////////////////////////////////////////
// character format
//////////////////////////////////////////////////

`define dataBits 8 // bits per character, lsb first on the line

// one stop bit, counted in oversampling ticks
`define sbTick 16

//////////////////////////////////////////////////
// queues
//////////////////////////////////////////////////

`define fifoDepth 16 // entries per direction
`define fifoAddrLen 4 // pointer width, 2^4 = fifoDepth

//////////////////////////////////////////////////
// bit timing
//////////////////////////////////////////////////

// clocks between two oversampling ticks
// 16 ticks per bit -> 64 clocks per bit, 640 per frame
`define baudDivisor 4

`endif

//--- uartPkg.sv
`include "uart_consts.svh"

package uartPkg;

	typedef logic [`dataBits-1:0] byteT; // one character
	typedef logic [7:0] statusT; // host status byte
	typedef logic [`fifoAddrLen:0] fifoCntT; // 0 .. fifoDepth
	typedef logic [3:0] tickCntT; // oversampling tick counter

	// receiver fsm
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxStateT;

	// transmitter fsm
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txStateT;

endpackage

//--- baudGen.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

// free running divider, one tick per baudDivisor clocks
module baudGen
(
	input logic clk,
	input logic reset,
	output logic sTick
);

	logic [$clog2(`baudDivisor)-1:0] count;
	logic wrap;

	assign wrap = (count == `baudDivisor-1); // last clock of the period

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else if (wrap)
		begin
			count <= '0; // restart period
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	// single cycle pulse on the wrap clock
	assign sTick = wrap;

endmodule

//--- uartRec.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

// 16x oversampling receiver, one start, dataBits data, one stop
module uartRec
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rx,
	output logic rxDoneTick,
	output uartPkg::byteT dOut
);

	uartPkg::rxStateT stateReg, stateNext; // fsm state
	uartPkg::tickCntT sReg, sNext; // ticks within a bit
	logic [$clog2(`dataBits)-1:0] nReg, nNext; // data bits received
	uartPkg::byteT bReg, bNext; // shift register
	logic rxMeta, rxSync; // line synchronizer

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1; // idle line is high
			rxSync <= 1'b1;
			stateReg <= uartPkg::rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	// received data, no reset needed
	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////////////////////////
	// next state logic
	//////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			uartPkg::rxIdle:
				if (!rxSync) // falling edge of start bit
				begin
					stateNext = uartPkg::rxStart;
					sNext = '0;
				end
			uartPkg::rxStart:
				if (sTick)
				begin
					if (sReg == 4'd7) // middle of start bit
					begin
						stateNext = uartPkg::rxData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxData:
				if (sTick)
				begin
					if (sReg == 4'd15) // middle of a data bit
					begin
						sNext = '0;
						bNext = {rxSync, bReg[`dataBits-1:1]}; // lsb arrives first
						if (nReg == `dataBits-1)
							stateNext = uartPkg::rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStop:
				if (sTick)
				begin
					if (sReg == `sbTick-1) // stop bit finished
					begin
						stateNext = uartPkg::rxIdle;
						rxDoneTick = 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::rxIdle;
		endcase
	end

	assign dOut = bReg;

endmodule

//--- uartTrans.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

// serializer, pulls bytes from the tx queue and frames them
module uartTrans
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic txEmpty,
	input uartPkg::byteT txHead,
	output logic txPop,
	output logic tx,
	output logic txBusy
);

	uartPkg::txStateT stateReg, stateNext;
	uartPkg::tickCntT sReg, sNext; // ticks within a bit
	logic [$clog2(`dataBits)-1:0] nReg, nNext; // data bits sent
	uartPkg::byteT bReg, bNext; // outgoing shift register
	logic txReg, txNext; // registered line driver

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1; // line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
	end

	//////////////////////////////////////////////////
	// frame sequencing
	//////////////////////////////////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txNext = txReg;
		txPop = 1'b0;

		case (stateReg)
			uartPkg::txIdle:
				if (!txEmpty) // pop and latch head in one cycle
				begin
					txPop = 1'b1;
					bNext = txHead;
					stateNext = uartPkg::txStart;
					sNext = '0;
					txNext = 1'b0; // start bit
				end
			uartPkg::txStart:
				if (sTick)
				begin
					if (sReg == 4'd15)
					begin
						stateNext = uartPkg::txData;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0]; // first data bit
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txData:
				if (sTick)
				begin
					if (sReg == 4'd15)
					begin
						sNext = '0;
						bNext = {1'b0, bReg[`dataBits-1:1]};
						if (nReg == `dataBits-1)
						begin
							stateNext = uartPkg::txStop;
							txNext = 1'b1; // stop bit
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1]; // next bit after shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txStop:
				if (sTick)
				begin
					if (sReg == `sbTick-1)
						stateNext = uartPkg::txIdle; // line already high
					else
						sNext = sReg + 1'b1;
				end
			default:
				stateNext = uartPkg::txIdle;
		endcase
	end

	assign tx = txReg;
	assign txBusy = (stateReg != uartPkg::txIdle);

endmodule

//--- uartFifo.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

// show-ahead byte queue, head always visible on dout
module uartFifo
(
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input uartPkg::byteT din,
	output uartPkg::byteT dout,
	output logic full,
	output logic empty,
	output uartPkg::fifoCntT count
);

	uartPkg::byteT mem [0:`fifoDepth-1]; // storage
	logic [`fifoAddrLen-1:0] wrPtr, rdPtr;
	uartPkg::fifoCntT countReg;
	logic doPush, doPop;

	assign full = (countReg == `fifoDepth);
	assign empty = (countReg == '0);
	assign doPush = push && !full; // overflow ignored
	assign doPop = pop && !empty; // underflow ignored

	// pointers and fill level
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			countReg <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1; // wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: countReg <= countReg + 1'b1;
				2'b01: countReg <= countReg - 1'b1;
				default: countReg <= countReg; // none, or both at once
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= din;
	end

	assign dout = mem[rdPtr];
	assign count = countReg;

endmodule

//--- uartHostPort.sv
`timescale 1ns/1ps

// processor side, strobe gating, read data and status
module uartHostPort
(
	input logic clk,
	input logic reset,
	input logic rd,
	input logic wr,
	input logic statRd,
	input logic rxDoneTick,
	input logic rxFull,
	input logic rxEmpty,
	input logic txFull,
	input logic txBusy,
	input uartPkg::byteT wrData,
	input uartPkg::byteT rxByte,
	input uartPkg::byteT rxHead,
	output logic rxPush,
	output logic rxPop,
	output logic txPush,
	output uartPkg::byteT rxDin,
	output uartPkg::byteT txDin,
	output uartPkg::byteT rdData,
	output uartPkg::statusT status
);

	logic overrunReg; // sticky, rx byte lost
	logic dropReg; // sticky, tx byte lost

	// strobes only reach a queue that can take them
	assign rxPush = rxDoneTick && !rxFull;
	assign rxPop = rd && !rxEmpty;
	assign txPush = wr && !txFull;

	assign rxDin = rxByte; // receiver byte into rx queue
	assign txDin = wrData; // host byte into tx queue

	// a new loss wins over a clear in the same cycle
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrunReg <= 1'b0;
			dropReg <= 1'b0;
		end
		else
		begin
			if (rxDoneTick && rxFull)
				overrunReg <= 1'b1;
			else if (statRd)
				overrunReg <= 1'b0;
			if (wr && txFull)
				dropReg <= 1'b1;
			else if (statRd)
				dropReg <= 1'b0;
		end
	end

	assign rdData = rxEmpty ? '0 : rxHead; // zero when nothing queued
	assign status = {3'b000, txBusy, dropReg, overrunReg, txFull, !rxEmpty};

endmodule

//--- uartCore.sv
`timescale 1ns/1ps

// uart peripheral top, tick source, both paths and host port
module uartCore
(
	input logic clk,
	input logic reset,
	input logic rx,
	input logic rd,
	input logic wr,
	input logic statRd,
	input uartPkg::byteT wrData,
	output logic tx,
	output uartPkg::byteT rdData,
	output uartPkg::statusT status
);

	logic sTick; // oversampling tick
	logic rxDoneTick;
	uartPkg::byteT rxByte, rxDin, rxHead; // receive path
	logic rxPush, rxPop, rxFull, rxEmpty;
	uartPkg::byteT txDin, txHead; // transmit path
	logic txPush, txPop, txFull, txEmpty, txBusy;

	//////////////////////////////////////////////////
	// timing and serial paths
	//////////////////////////////////////////////////

	baudGen tickGen (.clk(clk), .reset(reset), .sTick(sTick));

	uartRec receiver (.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .dOut(rxByte));

	uartTrans transmitter (.clk(clk), .reset(reset), .sTick(sTick), .txEmpty(txEmpty),
		.txHead(txHead), .txPop(txPop), .tx(tx), .txBusy(txBusy));

	//////////////////////////////////////////////////
	// queues, fill counts not used at this level
	//////////////////////////////////////////////////

	uartFifo rxFifo (.clk(clk), .reset(reset), .push(rxPush), .pop(rxPop), .din(rxDin),
		.dout(rxHead), .full(rxFull), .empty(rxEmpty), .count());

	uartFifo txFifo (.clk(clk), .reset(reset), .push(txPush), .pop(txPop), .din(txDin),
		.dout(txHead), .full(txFull), .empty(txEmpty), .count());

	// host side
	uartHostPort hostPort (.clk(clk), .reset(reset), .rd(rd), .wr(wr), .statRd(statRd),
		.rxDoneTick(rxDoneTick), .rxFull(rxFull), .rxEmpty(rxEmpty), .txFull(txFull),
		.txBusy(txBusy), .wrData(wrData), .rxByte(rxByte), .rxHead(rxHead),
		.rxPush(rxPush), .rxPop(rxPop), .txPush(txPush), .rxDin(rxDin), .txDin(txDin),
		.rdData(rdData), .status(status));

endmodule

//--- uartCore_assertions.sv
`timescale 1ns/1ps

// protocol checks on receiver, host port and tx line
module uartCoreAssertions
(
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rxDoneTick,
	input logic rxFull,
	input logic tx,
	input logic txBusy,
	input uartPkg::statusT status
);

	// done only lands on an oversampling tick
	doneOnTick: assert property (@(posedge clk) disable iff (reset) rxDoneTick |-> sTick)
		else $error("rxDoneTick high without sTick");

	doneOneCycle: assert property (@(posedge clk) disable iff (reset) rxDoneTick |=> !rxDoneTick)
		else $error("rxDoneTick longer than one cycle");

	// byte arriving at a full rx queue is lost and flagged
	fullQueueFlagsOverrun: assert property (@(posedge clk) disable iff (reset)
		rxDoneTick && rxFull |=> status[2])
		else $error("rx byte lost at full queue without overrun flag");

	idleLineHigh: assert property (@(posedge clk) disable iff (reset) !txBusy |-> tx)
		else $error("tx low while transmitter idle");

endmodule

bind uartCore uartCoreAssertions protocolChecks (.clk(clk), .reset(reset), .sTick(sTick),
	.rxDoneTick(rxDoneTick), .rxFull(rxFull), .tx(tx), .txBusy(txBusy), .status(status));

//--- uartCore_tb.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

// loopback testbench with tx wired straight back into rx
module uartCore_tb;

	localparam int maxCmds = 64; // pattern table rows
	localparam int frameClks = (`dataBits + 2) * `sbTick * `baudDivisor; // 640 clocks

	logic clk = 1'b0;
	logic reset, rd, wr, statRd;
	logic serial; // tx looped to rx
	uartPkg::byteT wrData, rdData;
	uartPkg::statusT status;
	logic [7:0] pat [0:3*maxCmds-1]; // op, data, expected
	uartPkg::byteT tracked [$]; // bytes the tx queue took during a fill
	int errors, checks, limit;
	int cycles = 0;

	uartCore u_dut (.clk(clk), .reset(reset), .rx(serial), .rd(rd), .wr(wr), .statRd(statRd),
		.wrData(wrData), .tx(serial), .rdData(rdData), .status(status));

	always #20 clk = ~clk; // 40 ns period

	// limit is set once the patterns are loaded
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout, commands still running after %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// host bus helpers
	//////////////////////////////////////////////////

	task automatic compareValue(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic writeByte(input uartPkg::byteT b);
		@(posedge clk);
		wr <= 1'b1;
		wrData <= b;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic readCheck(input string name, input uartPkg::byteT expected);
		@(negedge clk);
		compareValue(name, expected, rdData); // head shows before the pop
		@(posedge clk);
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
	endtask

	task automatic statusCheck(input string name, input uartPkg::statusT expected);
		@(negedge clk);
		compareValue(name, expected, status);
		@(posedge clk);
		statRd <= 1'b1; // clears sticky bits
		@(posedge clk);
		statRd <= 1'b0;
	endtask

	task automatic waitAvailable();
		@(negedge clk);
		while (!status[0])
			@(negedge clk);
	endtask

	// one write per clock until a write meets a full tx queue
	task automatic fillTxQueue(input uartPkg::byteT first);
		uartPkg::byteT b;
		logic seenFull;
		b = first;
		seenFull = 1'b0;
		while (!seenFull)
		begin
			@(posedge clk);
			wr <= 1'b1;
			wrData <= b;
			@(negedge clk);
			seenFull = status[1]; // full during the write cycle means dropped
			if (!seenFull)
				tracked.push_back(b);
			b = b + 8'd1;
		end
		@(posedge clk);
		wr <= 1'b0;
	endtask

	task automatic drainTracked();
		uartPkg::byteT b;
		while (tracked.size() > 0)
		begin
			b = tracked.pop_front();
			waitAvailable();
			readCheck($sformatf("fill byte %h", b), b);
		end
	endtask

	//////////////////////////////////////////////////
	// command sequencer
	//////////////////////////////////////////////////

	initial
	begin
		int op, arg, expd, frames;
		reset <= 1'b1;
		rd <= 1'b0;
		wr <= 1'b0;
		statRd <= 1'b0;
		wrData <= '0;
		errors = 0;
		checks = 0;
		frames = 0;
		for (int i = 0; i < 3 * maxCmds; i++)
			pat[i] = 8'h00; // op 0 ends the list
		$readmemh("uart_patterns.txt", pat);
		for (int i = 0; i < maxCmds && pat[3*i] != 8'h00; i++)
		begin
			if (pat[3*i] == 8'h05)
				frames += int'(pat[3*i+1]); // idle length
			else if (pat[3*i] == 8'h07)
				frames += `fifoDepth + 1; // one frame per drained byte
			else
				frames += 1;
		end
		limit = frames * 700 + 2000;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < maxCmds && pat[3*i] != 8'h00; i++)
		begin
			op = int'(pat[3*i]);
			arg = int'(pat[3*i+1]);
			expd = int'(pat[3*i+2]);
			case (op)
				1: for (int k = 0; k < expd; k++)
					writeByte(uartPkg::byteT'(arg + k));
				2: waitAvailable();
				3: for (int k = 0; k < arg; k++)
					readCheck($sformatf("cmd %0d read %0d", i, k), uartPkg::byteT'(expd + k));
				4: statusCheck($sformatf("cmd %0d status", i), uartPkg::statusT'(expd));
				5: repeat (arg * frameClks) @(posedge clk);
				6: fillTxQueue(uartPkg::byteT'(arg));
				7: drainTracked();
				default:
				begin
					errors++;
					$display("unknown operation code %0d in command %0d", op, i);
				end
			endcase
		end

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- uart_patterns.txt
// columns are op code, data byte, expected byte in hex, op 00 ends the list
// 1 write run (expected = count) 2 wait rx data 3 read run (data = count) 4 status 5 idle frames 6 fill 7 drain
04 00 00
03 01 00
01 a5 01
02 00 00
03 01 a5
05 01 00
04 00 00
01 11 05
04 00 10
05 06 00
03 05 11
04 00 00
01 01 10
05 02 00
01 11 02
05 12 00
04 00 05
04 00 01
03 10 01
04 00 00
06 40 00
04 00 1a
07 00 00
05 01 00
04 00 00
00 00 00

//--- compile.f
+incdir+.
uartPkg.sv
baudGen.sv
uartRec.sv
uartTrans.sv
uartFifo.sv
uartHostPort.sv
uartCore.sv
uartCore_assertions.sv
uartCore_tb.sv

//--- Makefile
# Verilator build and run of the UART loopback testbench

sim:
	verilator --binary --timing --assert --top-module uartCore_tb -f compile.f -o simv
	out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
